// ==== project.f ====
+incdir+dv
hw/rf_ecc_pkg.sv
hw/rf_check_if.sv
hw/rf_ecc_mem.sv
hw/rf_read_check.sv
hw/rf_alert_merge.sv
hw/rf_ecc_top.sv
dv/tb_rf_ecc.sv

// ==== Bender.yml ====
package:
  name: rf_ecc

sources:
  - files:
      - hw/rf_ecc_pkg.sv
      - hw/rf_check_if.sv
      - hw/rf_ecc_mem.sv
      - hw/rf_read_check.sv
      - hw/rf_alert_merge.sv
      - hw/rf_ecc_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_rf_ecc.sv

// ==== dv/tb_rf_ecc_ref.svh ====
// Shadow data array, reference code words, encode rule and read fault prediction
`ifndef TB_RF_ECC_REF_SVH
`define TB_RF_ECC_REF_SVH

// Data last written to each register
logic [DATA_WIDTH-1:0] shadow_q [NUM_REGS];
// Code word the storage should hold, glitches included
logic [CODE_WIDTH-1:0] ref_code [NUM_REGS];
// Set while a register carries a glitch that no write has cleared
logic                  glitched [NUM_REGS];

// Each check bit is the parity over its mask, inverted by the default pattern
function automatic logic [CODE_WIDTH-1:0] encode_word(input logic [DATA_WIDTH-1:0] d);
  logic [ECC_WIDTH-1:0] chk;
  for (int b = 0; b < ECC_WIDTH; b++) begin
    chk[b] = (^(d & ECC_MASKS[b])) ^ ECC_DEFAULT[b];
  end
  return {chk, d};
endfunction

// Every register back to zero data with check bits 0x2A
function automatic void clear_model();
  for (int r = 0; r < NUM_REGS; r++) begin
    shadow_q[r] = '0;
    ref_code[r] = {ECC_DEFAULT, {DATA_WIDTH{1'b0}}};
    glitched[r] = 1'b0;
  end
endfunction

// Applies one clock edge worth of writes and glitches
// A glitch beats a write only when both target the same register
function automatic void apply_edge(input logic wr_en, input logic [ADDR_WIDTH-1:0] wr_addr,
                                   input logic [DATA_WIDTH-1:0] wr_data, input logic gl_en,
                                   input logic [ADDR_WIDTH-1:0] gl_addr,
                                   input logic [CODE_WIDTH-1:0] gl_mask);
  if (gl_en && gl_addr != '0) begin
    ref_code[gl_addr] = ref_code[gl_addr] ^ gl_mask;
    glitched[gl_addr] = 1'b1;
  end
  if (wr_en && wr_addr != '0 && !(gl_en && gl_addr == wr_addr)) begin
    ref_code[wr_addr] = encode_word(wr_data);
    shadow_q[wr_addr] = wr_data;
    glitched[wr_addr] = 1'b0;
  end
endfunction

// Expected read data, taken from the raw data bits once a glitch has hit
function automatic logic [DATA_WIDTH-1:0] expected_data(input logic [ADDR_WIDTH-1:0] addr);
  if (addr == '0) begin
    return '0;
  end
  return glitched[addr] ? ref_code[addr][DATA_WIDTH-1:0] : shadow_q[addr];
endfunction

// Predicted fault of one read port in the current cycle
function automatic logic predict_fault(input logic re, input logic [ADDR_WIDTH-1:0] addr);
  logic [CODE_WIDTH-1:0] code;
  logic [CODE_WIDTH-1:0] fresh;
  logic                  bad;
  code  = ref_code[addr];
  fresh = encode_word(code[DATA_WIDTH-1:0]);
  // Check bit mismatch or a stuck word
  bad   = (code[CODE_WIDTH-1:DATA_WIDTH] != fresh[CODE_WIDTH-1:DATA_WIDTH]) ||
          (code == '0) || (code == '1);
  return re && (addr != '0) && bad;
endfunction

`endif

// ==== dv/tb_rf_ecc.sv ====
// Testbench tb_rf_ecc with clock, reset, stimulus tasks, compare process and final report
`timescale 1ns/1ns

module tb_rf_ecc
  import rf_ecc_pkg::*;
();

  localparam logic [31:0] LCG_SEED   = 32'd93127;
  localparam int          WAIT_LIMIT = 8;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  we;
  logic [ADDR_WIDTH-1:0] waddr;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  rs1_re;
  logic [ADDR_WIDTH-1:0] rs1_addr;
  logic                  rs2_re;
  logic [ADDR_WIDTH-1:0] rs2_addr;
  logic                  fault_we;
  logic [ADDR_WIDTH-1:0] fault_addr;
  logic [CODE_WIDTH-1:0] fault_mask;
  logic [DATA_WIDTH-1:0] rs1_data;
  logic [DATA_WIDTH-1:0] rs2_data;
  logic                  alert_major;
  logic                  fault_valid;
  logic [ADDR_WIDTH-1:0] fault_addr_q;

  int                    check_count = 0;
  int                    error_count = 0;
  logic [31:0]           lcg_state = LCG_SEED;
  // Expected alert, first fault flag and first fault address
  logic                  pred_prev;
  logic                  exp_fv;
  logic [ADDR_WIDTH-1:0] exp_faddr;

  `include "tb_rf_ecc_ref.svh"

  rf_ecc_top u_rf_ecc_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Random glitch mask with exactly nbits set
  function automatic logic [CODE_WIDTH-1:0] make_mask(input int nbits);
    logic [CODE_WIDTH-1:0] m;
    m = '0;
    while ($countones(m) < nbits) begin
      m[(lcg_next() >> 8) % CODE_WIDTH] = 1'b1;
    end
    return m;
  endfunction

  // Random register in 1 to 31
  function automatic logic [ADDR_WIDTH-1:0] rand_reg();
    return ADDR_WIDTH'(1 + ((lcg_next() >> 8) % (NUM_REGS - 1)));
  endfunction

  task automatic check_value(input string name, input logic [CODE_WIDTH-1:0] got,
                             input logic [CODE_WIDTH-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    we       <= 1'b0;
    rs1_re   <= 1'b0;
    rs2_re   <= 1'b0;
    fault_we <= 1'b0;
  endtask

  task automatic write_reg(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
    go_idle();
    we    <= 1'b1;
    waddr <= a;
    wdata <= d;
  endtask

  task automatic read_regs(input logic re1, input logic [ADDR_WIDTH-1:0] a1,
                           input logic re2, input logic [ADDR_WIDTH-1:0] a2);
    go_idle();
    rs1_re   <= re1;
    rs1_addr <= a1;
    rs2_re   <= re2;
    rs2_addr <= a2;
  endtask

  // Glitch one register, optionally with a write to it in the same cycle
  task automatic inject_glitch(input logic [ADDR_WIDTH-1:0] a, input logic [CODE_WIDTH-1:0] m,
                               input logic wr, input logic [DATA_WIDTH-1:0] d);
    go_idle();
    we         <= wr;
    waddr      <= a;
    wdata      <= d;
    fault_we   <= 1'b1;
    fault_addr <= a;
    fault_mask <= m;
  endtask

  task automatic pulse_reset();
    go_idle();
    rst_ni <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Polls alert_major (sel 0) or fault_valid (sel 1) at the falling edge
  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while ((sel ? fault_valid : alert_major) !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    check_count++;
    if ((sel ? fault_valid : alert_major) !== 1'b1) begin
      error_count++;
      $display("Flag did not rise after %s within %0d cycles", what, WAIT_LIMIT);
    end
  endtask

  // Samples mid-cycle, then moves the model over the coming rising edge
  always @(negedge clk_i) begin : compare
    logic f1;
    logic f2;
    if (!rst_ni) begin
      clear_model();
      pred_prev = 1'b0;
      exp_fv    = 1'b0;
      exp_faddr = '0;
    end else begin
      check_value("rs1_data", rs1_data, expected_data(rs1_addr));
      check_value("rs2_data", rs2_data, expected_data(rs2_addr));
      check_value("alert_major", alert_major, pred_prev);
      check_value("fault_valid", fault_valid, exp_fv);
      check_value("fault_addr_q", fault_addr_q, exp_faddr);
      f1 = predict_fault(rs1_re, rs1_addr);
      f2 = predict_fault(rs2_re, rs2_addr);
      // First fault wins with rs1 ahead of rs2
      if ((f1 || f2) && !exp_fv) begin
        exp_fv    = 1'b1;
        exp_faddr = f1 ? rs1_addr : rs2_addr;
      end
      pred_prev = f1 || f2;
      apply_edge(we, waddr, wdata, fault_we, fault_addr, fault_mask);
    end
  end

  initial begin : stimulus
    logic [ADDR_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] d;
    {rst_ni, we, rs1_re, rs2_re, fault_we} = '0;
    {waddr, rs1_addr, rs2_addr, fault_addr} = '0;
    wdata      = '0;
    fault_mask = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Every register reads zero right after reset
    for (int i = 0; i < NUM_REGS; i++) begin
      read_regs(1'b1, ADDR_WIDTH'(i), 1'b1, ADDR_WIDTH'(NUM_REGS - 1 - i));
    end

    // Random writes with register 0 included, then reads on both ports
    for (int i = 0; i < 40; i++) begin
      write_reg(ADDR_WIDTH'(lcg_next() >> 8), lcg_next());
    end
    write_reg('0, 32'hDEAD_BEEF);
    for (int i = 0; i < NUM_REGS; i++) begin
      read_regs(1'b1, ADDR_WIDTH'(i), 1'b1, ADDR_WIDTH'(lcg_next() >> 8));
    end
    go_idle();
    @(negedge clk_i);
    check_value("fault_valid", fault_valid, 1'b0);

    // Reset clears the record before both ports fault together and rs1 takes it
    pulse_reset();
    inject_glitch(5'd12, make_mask(1), 1'b0, '0);
    inject_glitch(5'd7, make_mask(1), 1'b0, '0);
    read_regs(1'b1, 5'd12, 1'b1, 5'd7);
    go_idle();
    wait_high(1, "a fault on both ports");
    check_value("fault_addr_q", fault_addr_q, 5'd12);
    // A later fault leaves the record alone
    read_regs(1'b0, 5'd0, 1'b1, 5'd7);
    go_idle();
    @(negedge clk_i);
    check_value("fault_addr_q", fault_addr_q, 5'd12);

    // One and two bit glitches are read without re, then with re, and then repaired
    for (int i = 0; i < 10; i++) begin
      a = rand_reg();
      write_reg(a, lcg_next());
      inject_glitch(a, make_mask(1 + (i % 2)), 1'b0, '0);
      read_regs(1'b0, a, 1'b0, a);
      if (i % 2 == 0) begin
        read_regs(1'b1, a, 1'b0, '0);
      end else begin
        read_regs(1'b0, '0, 1'b1, a);
      end
      go_idle();
      wait_high(0, "a glitched read");
      write_reg(a, lcg_next());
      read_regs(1'b1, a, 1'b1, a);
      go_idle();
      @(negedge clk_i);
      check_value("alert_major", alert_major, 1'b0);
    end

    // Glitches that leave an all-zero and an all-one code word
    a = rand_reg();
    d = lcg_next();
    write_reg(a, d);
    inject_glitch(a, encode_word(d), 1'b0, '0);
    read_regs(1'b1, a, 1'b0, '0);
    go_idle();
    wait_high(0, "an all-zero code word read");
    d = lcg_next();
    write_reg(a, d);
    inject_glitch(a, ~encode_word(d), 1'b0, '0);
    read_regs(1'b0, '0, 1'b1, a);
    go_idle();
    wait_high(0, "an all-one code word read");

    // The glitch wins over a write to the same register in the same cycle
    // The register starts from a clean code word so one flipped bit always shows
    a = rand_reg();
    write_reg(a, lcg_next());
    inject_glitch(a, make_mask(1), 1'b1, lcg_next());
    read_regs(1'b1, a, 1'b0, '0);
    go_idle();
    wait_high(0, "a glitch racing a write");
    write_reg(a, lcg_next());
    read_regs(1'b1, a, 1'b1, a);
    go_idle();
    repeat (3) @(negedge clk_i);

    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== hw/rf_ecc_top.sv ====
// Module rf_ecc_top, ECC register file top with storage, two read checkers and the alert merge
`timescale 1ns/1ns

module rf_ecc_top
  import rf_ecc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write port
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  // Read ports
  input  logic                  rs1_re,
  input  logic [ADDR_WIDTH-1:0] rs1_addr,
  input  logic                  rs2_re,
  input  logic [ADDR_WIDTH-1:0] rs2_addr,
  // Glitch port
  input  logic                  fault_we,
  input  logic [ADDR_WIDTH-1:0] fault_addr,
  input  logic [CODE_WIDTH-1:0] fault_mask,
  output logic [DATA_WIDTH-1:0] rs1_data,
  output logic [DATA_WIDTH-1:0] rs2_data,
  // Alert and first-fault record
  output logic                  alert_major,
  output logic                  fault_valid,
  output logic [ADDR_WIDTH-1:0] fault_addr_q
);

  // Raw code words from storage to the checkers
  logic [CODE_WIDTH-1:0] rs1_code;
  logic [CODE_WIDTH-1:0] rs2_code;

  // One check result bundle per read port
  rf_check_if rs1_chk_if ();
  rf_check_if rs2_chk_if ();

  rf_ecc_mem u_rf_ecc_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we         (we),
    .waddr      (waddr),
    .wdata      (wdata),
    .fault_we   (fault_we),
    .fault_addr (fault_addr),
    .fault_mask (fault_mask),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_code   (rs1_code),
    .rs2_code   (rs2_code)
  );

  // Both ports are checked side by side in the same cycle
  rf_read_check u_check_rs1 (
    .re   (rs1_re),
    .addr (rs1_addr),
    .code (rs1_code),
    .data (rs1_data),
    .chk  (rs1_chk_if.check)
  );

  rf_read_check u_check_rs2 (
    .re   (rs2_re),
    .addr (rs2_addr),
    .code (rs2_code),
    .data (rs2_data),
    .chk  (rs2_chk_if.check)
  );

  rf_alert_merge u_alert_merge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rs1_chk      (rs1_chk_if.merge),
    .rs2_chk      (rs2_chk_if.merge),
    .alert_major  (alert_major),
    .fault_valid  (fault_valid),
    .fault_addr_q (fault_addr_q)
  );

endmodule

// ==== hw/rf_alert_merge.sv ====
// Module rf_alert_merge, registered major alert and first-fault address capture for both read ports
`timescale 1ns/1ns

module rf_alert_merge
  import rf_ecc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  rf_check_if.merge             rs1_chk,
  rf_check_if.merge             rs2_chk,
  // One-cycle pulse after each faulty read cycle
  output logic                  alert_major,
  // Set by the first fault, held until reset
  output logic                  fault_valid,
  output logic [ADDR_WIDTH-1:0] fault_addr_q
);

  logic                  fault_any;
  logic [ADDR_WIDTH-1:0] fault_addr_d;
  logic                  capture;

  // Either port faulting this cycle
  assign fault_any = rs1_chk.fault || rs2_chk.fault;

  // rs1 has priority when both ports fault together
  assign fault_addr_d = rs1_chk.fault ? rs1_chk.addr : rs2_chk.addr;

  // Capture only once, later faults leave the record alone
  assign capture = fault_any && !fault_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      alert_major  <= 1'b0;
      fault_valid  <= 1'b0;
      fault_addr_q <= '0;
    end else begin
      // Follows the fault flags with one cycle of delay
      alert_major <= fault_any;
      if (capture) begin
        fault_valid  <= 1'b1;
        fault_addr_q <= fault_addr_d;
      end
    end
  end

endmodule

// ==== hw/rf_read_check.sv ====
// Module rf_read_check, decodes one read port and flags ECC and all-same code word faults
`timescale 1ns/1ns

module rf_read_check
  import rf_ecc_pkg::*;
(
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] addr,
  // Code word as read from storage
  input  logic [CODE_WIDTH-1:0] code,
  // Data bits of the word, zero for register 0
  output logic [DATA_WIDTH-1:0] data,
  rf_check_if.check             chk
);

  logic [ECC_WIDTH-1:0] syndrome;
  logic                 addr_nz;
  logic                 ecc_err;
  logic                 same_err;

  // Register 0 is never checked
  assign addr_nz = (addr != '0);

  // Nonzero syndrome catches every one and two bit flip
  assign syndrome = ecc_syndrome(code);
  assign ecc_err  = |syndrome;

  // Stuck-at patterns across the whole word, e.g. a lost supply
  // These are caught here as well since the inverted check bits make them invalid
  assign same_err = (code == '0) || (code == '1);

  // Strip the check bits
  assign data = addr_nz ? code[DATA_WIDTH-1:0] : '0;

  // Result for the alert merge
  assign chk.re       = re;
  assign chk.addr     = addr;
  assign chk.ecc_err  = ecc_err;
  assign chk.same_err = same_err;
  // Only an active read of a real register can fault
  assign chk.fault    = re && addr_nz && (ecc_err || same_err);

endmodule

// ==== hw/rf_ecc_mem.sv ====
// Module rf_ecc_mem, code word storage with write encoding, glitch injection and two read ports
`timescale 1ns/1ns

module rf_ecc_mem
  import rf_ecc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write port
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  // Glitch port, flips stored bits in place
  input  logic                  fault_we,
  input  logic [ADDR_WIDTH-1:0] fault_addr,
  input  logic [CODE_WIDTH-1:0] fault_mask,
  // Read addresses
  input  logic [ADDR_WIDTH-1:0] rs1_addr,
  input  logic [ADDR_WIDTH-1:0] rs2_addr,
  // Raw code words, unchecked
  output logic [CODE_WIDTH-1:0] rs1_code,
  output logic [CODE_WIDTH-1:0] rs2_code
);

  // Storage for registers 1 to 31
  logic [CODE_WIDTH-1:0] mem_q [1:NUM_REGS-1];
  // Full read view with register 0 included
  logic [CODE_WIDTH-1:0] rd_view [NUM_REGS];
  // Encoded write data, shared by all registers
  logic [CODE_WIDTH-1:0] wcode;

  assign wcode = ecc_encode(wdata);

  // Register 0 is hardwired to the clean zero code word
  // It takes no writes and no glitches, so it always decodes as zero
  assign rd_view[0] = CODE_RESET;

  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    logic wr_hit;
    logic glitch_hit;

    // Address decode for this register
    assign wr_hit     = we && (waddr == ADDR_WIDTH'(i));
    assign glitch_hit = fault_we && (fault_addr == ADDR_WIDTH'(i));

    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        // Zero data with its matching check bits
        mem_q[i] <= CODE_RESET;
      end else if (glitch_hit) begin
        // A glitch wins over a write to the same register in the same cycle
        mem_q[i] <= mem_q[i] ^ fault_mask;
      end else if (wr_hit) begin
        mem_q[i] <= wcode;
      end
    end

    assign rd_view[i] = mem_q[i];
  end

  // Both reads are combinational from the address
  assign rs1_code = rd_view[rs1_addr];
  assign rs2_code = rd_view[rs2_addr];

endmodule

// ==== hw/rf_check_if.sv ====
// Interface rf_check_if with the check result of one read port
`timescale 1ns/1ns

interface rf_check_if
  import rf_ecc_pkg::*;
();

  // Port is reading in this cycle
  logic                  re;
  // Register being read
  logic [ADDR_WIDTH-1:0] addr;
  // Syndrome of the read code word is nonzero
  logic                  ecc_err;
  // Read code word is all zeros or all ones
  logic                  same_err;
  // Qualified fault on a real read of registers 1 to 31 with either error
  logic                  fault;

  // Driving side in each read checker
  modport check (
    output re, addr, ecc_err, same_err, fault
  );

  // Receiving side in the alert merge
  modport merge (
    input re, addr, ecc_err, same_err, fault
  );

endinterface

// ==== hw/rf_ecc_pkg.sv ====
// Register file sizes, reset code word, check bit masks and the ECC encode and syndrome functions
package rf_ecc_pkg;

  // Geometry of the RISC-V integer register file
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned ADDR_WIDTH = 5;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ECC_WIDTH  = 6;
  // Code word layout is {check bits, data bits}
  localparam int unsigned CODE_WIDTH = DATA_WIDTH + ECC_WIDTH;

  // Inverting pattern on the parity, so zero data carries check bits 6'h2A
  // This keeps the all-zero and all-one code words out of the valid set
  localparam logic [ECC_WIDTH-1:0] ECC_DEFAULT = 6'h2A;

  // Code word held by every register after reset and by the hardwired register 0
  localparam logic [CODE_WIDTH-1:0] CODE_RESET = {ECC_DEFAULT, {DATA_WIDTH{1'b0}}};

  // One mask per check bit, each check bit is the parity of the data bits it selects
  // Read column-wise, data bits 0 to 19 hit three check bits, 20 to 25 hit five and
  // 26 to 31 hit four, Hsiao-style odd weight as far as six check bits allow
  // All 32 columns are distinct and none is a single bit, so any one or two
  // flipped code word bits leave a nonzero syndrome
  localparam logic [DATA_WIDTH-1:0] ECC_MASKS [ECC_WIDTH] = '{
    32'hBDF1_2CB7,
    32'hDEF2_555B,
    32'hEF74_9A6D,
    32'h77B8_E38E,
    32'h7BDF_03F0,
    32'h83EF_FC00
  };

  // Builds the stored code word for one data word
  function automatic logic [CODE_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] data);
    logic [ECC_WIDTH-1:0] ecc;
    for (int i = 0; i < ECC_WIDTH; i++) begin
      ecc[i] = ^(data & ECC_MASKS[i]);
    end
    // Fold in the default pattern last
    ecc = ecc ^ ECC_DEFAULT;
    return {ecc, data};
  endfunction

  // Stored check bits against the check bits recomputed from the stored data
  // A zero result means data and check bits agree
  function automatic logic [ECC_WIDTH-1:0] ecc_syndrome(input logic [CODE_WIDTH-1:0] code);
    logic [CODE_WIDTH-1:0] fresh;
    fresh = ecc_encode(code[DATA_WIDTH-1:0]);
    return code[CODE_WIDTH-1:DATA_WIDTH] ^ fresh[CODE_WIDTH-1:DATA_WIDTH];
  endfunction

endpackage
